// ==== hdl/flash_pkg.sv ====
package flash_pkg;

	// ##########################################################################
	// Command opcodes and status bits
	// ##########################################################################

	localparam logic [7:0] op_wren         = 8'h06;
	localparam logic [7:0] op_rdsr         = 8'h05;
	localparam logic [7:0] op_sector_erase = 8'h20;
	localparam logic [7:0] op_page_program = 8'h02;
	localparam logic [7:0] op_read         = 8'h03;

	localparam int sr_busy_bit = 0;             // WIP bit of status register 1

	// ##########################################################################
	// Sizing
	// ##########################################################################

	localparam int mem_bytes       = 32;        // Bytes checked per pass, from address 0
	localparam int read_gap        = 16;        // Idle cycles before the read-back phase
	localparam int sclk_div        = 2;         // Clk cycles per half SCLK period
	localparam int max_frame_bytes = 5;

	// ##########################################################################
	// Frame and transfer descriptors
	// ##########################################################################

	typedef struct packed {
		logic [7:0]  opcode;
		logic [23:0] addr;
		logic [7:0]  data;
	} flash_cmd_t;

	// Sequencer fills the fields, engine shifts the bytes out from the top
	typedef union packed {
		flash_cmd_t                            cmd;
		logic [max_frame_bytes-1:0][7:0]       bytes;
	} flash_frame_u;

	typedef struct packed {
		logic [2:0] n_wr;                       // Bytes shifted out from the frame
		logic       n_rd;                       // One byte sampled after them when set
	} spi_xfer_t;

	typedef struct packed {
		logic [23:0] addr;
		logic [7:0]  data;
		logic [7:0]  seed;
		logic        last;
	} read_beat_t;

	typedef struct packed {
		logic [15:0] pass_no;
		logic [15:0] errors;
		logic [23:0] first_bad_addr;
	} pass_report_t;

endpackage

// ==== hdl/spi_shift_engine.sv ====
`timescale 1ns/100ps

module spi_shift_engine (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  flash_pkg::flash_frame_u   frame,
	input  flash_pkg::spi_xfer_t      xfer,
	input  logic                      miso,
	output logic                      sclk,
	output logic                      ss,
	output logic                      mosi,
	output logic [7:0]                rd_byte
);

	logic [7:0]                               div_cnt;
	logic [6:0]                               bits_left;    // Includes the bit on the wire
	logic [3:0]                               rd_bits;
	logic [8*flash_pkg::max_frame_bytes-1:0]  shift_reg;
	logic [3:0]                               n_bytes;
	logic                                     edge_tick;
	logic                                     rise_tick;
	logic                                     fall_tick;

	assign n_bytes   = {1'b0, xfer.n_wr} + {3'b000, xfer.n_rd};
	assign edge_tick = !ss && div_cnt == 8'(flash_pkg::sclk_div - 1);
	assign rise_tick = edge_tick && !sclk;
	assign fall_tick = edge_tick && sclk;

	// ##########################################################################
	// SCLK, chip select and MOSI
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			ss        <= 1'b1;
			sclk      <= 1'b0;
			mosi      <= 1'b0;
			div_cnt   <= '0;
			bits_left <= '0;
		end else if (ss) begin
			if (start) begin
				ss        <= 1'b0;
				div_cnt   <= '0;
				bits_left <= {n_bytes, 3'b000};
				mosi      <= frame.bytes[flash_pkg::max_frame_bytes-1][7];    // Mode 0 needs it early
			end
		end else if (edge_tick) begin
			div_cnt <= '0;
			sclk    <= !sclk;
			if (sclk) begin
				bits_left <= bits_left - 7'd1;
				if (bits_left == 7'd1) begin
					ss   <= 1'b1;                     // Last falling edge ends the frame
					mosi <= 1'b0;
				end else begin
					mosi <= shift_reg[8*flash_pkg::max_frame_bytes-2];
				end
			end
		end else begin
			div_cnt <= div_cnt + 8'd1;
		end
	end

	// ##########################################################################
	// Data shifting
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (ss && start) begin
			shift_reg <= frame.bytes;
			rd_bits   <= {xfer.n_rd, 3'b000};
		end else if (fall_tick) begin
			shift_reg <= {shift_reg[8*flash_pkg::max_frame_bytes-2:0], 1'b0};
		end
		if (rise_tick && bits_left <= {3'b000, rd_bits}) begin
			rd_byte <= {rd_byte[6:0], miso};      // Only the trailing read bits land here
		end
	end

	a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> ss ##1 (!ss && !sclk));

endmodule

// ==== hdl/readback_checker.sv ====
`timescale 1ns/100ps

module readback_checker (
	input  logic                      clk,
	input  logic                      rst,
	input  flash_pkg::read_beat_t     beat,
	input  logic                      beat_valid,
	output flash_pkg::pass_report_t   report,
	output logic                      report_valid
);

	logic [7:0]  expected;
	logic        mismatch;
	logic [15:0] pass_no;
	logic [15:0] errors;
	logic [15:0] errors_next;
	logic [23:0] first_bad;
	logic [23:0] first_bad_next;

	// Same pattern the sequencer programmed for this pass
	assign expected       = beat.seed + beat.addr[7:0];
	assign mismatch       = beat.data != expected;
	assign errors_next    = errors + {15'd0, mismatch};
	assign first_bad_next = (mismatch && errors == 16'd0) ? beat.addr : first_bad;

	// ##########################################################################
	// Per-pass counters
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			report_valid <= 1'b0;
			pass_no      <= 16'd1;
			errors       <= '0;
			first_bad    <= '0;
		end else begin
			report_valid <= 1'b0;
			if (beat_valid) begin
				if (beat.last) begin
					report_valid <= 1'b1;
					pass_no      <= pass_no + 16'd1;
					errors       <= '0;                   // Fresh count for the next pass
					first_bad    <= '0;
				end else begin
					errors    <= errors_next;
					first_bad <= first_bad_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid && beat.last) begin
			report.pass_no        <= pass_no;
			report.errors         <= errors_next;
			report.first_bad_addr <= first_bad_next;
		end
	end

endmodule

// ==== hdl/flash_cmd_sequencer.sv ====
`timescale 1ns/100ps

module flash_cmd_sequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ss,
	input  logic [7:0]                rd_byte,
	output flash_pkg::flash_frame_u   frame,
	output flash_pkg::spi_xfer_t      xfer,
	output logic                      start,
	output flash_pkg::read_beat_t     beat,
	output logic                      beat_valid
);

	typedef enum logic [2:0] {
		st_wren,
		st_erase,
		st_status,
		st_busy_check,
		st_program,
		st_program_next,
		st_read_gap,
		st_read
	} state_t;

	state_t      state;
	logic        in_flight;
	logic        ss_q;
	logic        ss_rise;
	logic [23:0] wr_addr;
	logic [23:0] rd_addr;
	logic [7:0]  seed;
	logic        erase_pending;
	logic        wren_seen;
	logic [15:0] gap_cnt;

	assign ss_rise = ss && !ss_q;

	// ##########################################################################
	// Pass state machine
	// ##########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= st_wren;
			start         <= 1'b0;
			beat_valid    <= 1'b0;
			in_flight     <= 1'b0;
			ss_q          <= 1'b1;
			wr_addr       <= '0;
			rd_addr       <= '0;
			seed          <= 8'd1;
			erase_pending <= 1'b1;
			wren_seen     <= 1'b0;
			gap_cnt       <= '0;
		end else begin
			ss_q       <= ss;
			start      <= 1'b0;
			beat_valid <= 1'b0;
			if (start && frame.cmd.opcode == flash_pkg::op_wren)
				wren_seen <= 1'b1;                 // Follows the frame actually sent
			if (in_flight) begin
				if (ss_rise) begin                 // Transfer done so rd_byte is now stable
					in_flight <= 1'b0;
					if (frame.cmd.opcode == flash_pkg::op_read) begin
						beat.addr  <= rd_addr;
						beat.data  <= rd_byte;
						beat.seed  <= seed;
						beat.last  <= rd_addr == 24'(flash_pkg::mem_bytes - 1);
						beat_valid <= 1'b1;
						rd_addr    <= rd_addr + 24'd1;
					end
				end
			end else begin
				case (state)
					st_wren: begin
						frame.cmd <= '{opcode: flash_pkg::op_wren, addr: '0, data: '0};
						xfer      <= '{n_wr: 3'd1, n_rd: 1'b0};
						start     <= 1'b1;
						in_flight <= 1'b1;
						state     <= erase_pending ? st_erase : st_program;
					end
					st_erase: begin
						frame.cmd <= '{opcode: flash_pkg::op_sector_erase, addr: '0, data: '0};
						xfer      <= '{n_wr: 3'd4, n_rd: 1'b0};
						start     <= 1'b1;
						in_flight <= 1'b1;
						state     <= st_status;
					end
					st_status: begin
						frame.cmd <= '{opcode: flash_pkg::op_rdsr, addr: '0, data: '0};
						xfer      <= '{n_wr: 3'd1, n_rd: 1'b1};
						start     <= 1'b1;
						in_flight <= 1'b1;
						state     <= st_busy_check;
					end
					st_busy_check: begin
						if (rd_byte[flash_pkg::sr_busy_bit]) begin
							state <= st_status;    // Still busy so poll again
						end else begin
							wren_seen <= 1'b0;     // Flash has dropped its WEL by now
							if (erase_pending) begin
								erase_pending <= 1'b0;
								state         <= st_wren;
							end else begin
								state <= st_program_next;
							end
						end
					end
					st_program: begin
						frame.cmd <= '{opcode: flash_pkg::op_page_program, addr: wr_addr,
							data: seed + wr_addr[7:0]};
						xfer      <= '{n_wr: 3'd5, n_rd: 1'b0};
						start     <= 1'b1;
						in_flight <= 1'b1;
						state     <= st_status;
					end
					st_program_next: begin
						if (wr_addr == 24'(flash_pkg::mem_bytes - 1)) begin
							gap_cnt <= '0;
							state   <= st_read_gap;
						end else begin
							wr_addr <= wr_addr + 24'd1;
							state   <= st_wren;
						end
					end
					st_read_gap: begin
						if (gap_cnt == 16'(flash_pkg::read_gap - 1)) begin
							rd_addr <= '0;
							state   <= st_read;
						end else begin
							gap_cnt <= gap_cnt + 16'd1;
						end
					end
					st_read: begin
						if (rd_addr == 24'(flash_pkg::mem_bytes)) begin
							seed          <= seed + 8'd1;    // Next pass writes a new pattern
							wr_addr       <= '0;
							rd_addr       <= '0;
							erase_pending <= 1'b1;
							state         <= st_wren;
						end else begin
							frame.cmd <= '{opcode: flash_pkg::op_read, addr: rd_addr, data: '0};
							xfer      <= '{n_wr: 3'd4, n_rd: 1'b1};
							start     <= 1'b1;
							in_flight <= 1'b1;
						end
					end
					default: state <= st_wren;
				endcase
			end
		end
	end

	// ##########################################################################
	// Checks
	// ##########################################################################

	a_start_ss_high: assert property (@(posedge clk) disable iff (rst)
		start |-> ss);

	// WEL must have been set again since the last completed erase or program
	a_program_after_wren: assert property (@(posedge clk) disable iff (rst)
		start && frame.cmd.opcode == flash_pkg::op_page_program |-> wren_seen);

endmodule

// ==== hdl/flash_exerciser_top.sv ====
`timescale 1ns/100ps

module flash_exerciser_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      miso,
	output logic                      sclk,
	output logic                      ss,
	output logic                      mosi,
	output flash_pkg::pass_report_t   report,
	output logic                      report_valid
);

	flash_pkg::flash_frame_u  frame;
	flash_pkg::spi_xfer_t     xfer;
	logic                     start;
	logic [7:0]               rd_byte;
	flash_pkg::read_beat_t    beat;
	logic                     beat_valid;

	flash_cmd_sequencer seq_i (
		.clk        (clk),
		.rst        (rst),
		.ss         (ss),
		.rd_byte    (rd_byte),
		.frame      (frame),
		.xfer       (xfer),
		.start      (start),
		.beat       (beat),
		.beat_valid (beat_valid)
	);

	spi_shift_engine spi_i (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.frame   (frame),
		.xfer    (xfer),
		.miso    (miso),
		.sclk    (sclk),
		.ss      (ss),                            // Also the end-of-transfer flag for the sequencer
		.mosi    (mosi),
		.rd_byte (rd_byte)
	);

	readback_checker chk_i (
		.clk          (clk),
		.rst          (rst),
		.beat         (beat),
		.beat_valid   (beat_valid),
		.report       (report),
		.report_valid (report_valid)
	);

endmodule

// ==== tb/spi_flash_model.sv ====
`timescale 1ns/100ps

module spi_flash_model (
	input  logic        sclk,
	input  logic        ss,
	input  logic        mosi,
	output logic        miso,
	input  logic [7:0]  busy_polls,        // Status polls that still show busy after a write
	input  logic        corrupt_en,
	input  logic [23:0] corrupt_addr,      // Read back with flipped bits while corrupt_en is set
	output int          violations,
	output int          erase_count,
	output int          program_count
);

	logic [7:0]  mem [0:4095];             // One 4 KB sector
	logic [39:0] in_shift;
	logic [7:0]  out_shift;
	logic [7:0]  opcode;
	logic [23:0] addr;
	int          bit_cnt;
	int          busy_left;
	logic        wel;
	logic        out_phase;

	function automatic int frame_bits(input logic [7:0] op);
		case (op)
			flash_pkg::op_wren:         return 8;
			flash_pkg::op_rdsr:         return 16;
			flash_pkg::op_sector_erase: return 32;
			default:                    return 40;
		endcase
	endfunction

	initial begin
		for (int i = 0; i < 4096; i++)
			mem[i] = 8'(i) ^ 8'(i >> 4) ^ 8'h3c;
		miso          = 1'b0;
		bit_cnt       = 0;
		busy_left     = 0;
		wel           = 1'b0;
		out_phase     = 1'b0;
		violations    = 0;
		erase_count   = 0;
		program_count = 0;
	end

	always @(negedge ss) begin
		bit_cnt   = 0;
		out_phase = 1'b0;
	end

	// ##########################################################################
	// Mode 0 bus side with commands in on rising SCLK and answers out on falling SCLK
	// ##########################################################################

	always @(posedge sclk) begin
		if (!ss) begin
			in_shift = {in_shift[38:0], mosi};
			bit_cnt  = bit_cnt + 1;
			if (bit_cnt == 8) begin
				opcode = in_shift[7:0];
				if (opcode == flash_pkg::op_rdsr) begin
					out_shift                         = '0;
					out_shift[1]                      = wel;
					out_shift[flash_pkg::sr_busy_bit] = busy_left != 0;
					out_phase                         = 1'b1;
				end
			end
			if (bit_cnt == 32 && opcode == flash_pkg::op_read) begin
				addr      = in_shift[23:0];
				out_shift = mem[addr[11:0]];
				if (corrupt_en && addr == corrupt_addr)
					out_shift = out_shift ^ 8'h5a;
				out_phase = 1'b1;
			end
		end
	end

	always @(negedge sclk) begin
		if (!ss && out_phase) begin
			miso      <= out_shift[7];
			out_shift = {out_shift[6:0], 1'b0};
		end
	end

	// A command takes effect when chip select goes high again
	always @(posedge ss) begin
		if (bit_cnt > 0) begin
			if (bit_cnt != frame_bits(opcode) || (busy_left != 0 && opcode != flash_pkg::op_rdsr))
				violations++;
			case (opcode)
				flash_pkg::op_wren: wel = 1'b1;
				flash_pkg::op_rdsr: begin
					if (busy_left == 1)
						wel = 1'b0;                // WEL drops when the write finishes
					if (busy_left > 0)
						busy_left--;
				end
				flash_pkg::op_sector_erase: begin
					if (!wel)
						violations++;
					for (int i = 0; i < 4096; i++)
						mem[i] = 8'hff;
					erase_count++;
					busy_left = busy_polls;
				end
				flash_pkg::op_page_program: begin
					if (!wel || erase_count == 0)
						violations++;
					mem[in_shift[19:8]] = mem[in_shift[19:8]] & in_shift[7:0];
					program_count++;
					busy_left = busy_polls;
				end
				flash_pkg::op_read: ;
				default: violations++;
			endcase
		end
	end

endmodule

// ==== tb/tb_flash_exerciser.sv ====
`timescale 1ns/100ps

module tb_flash_exerciser;

	localparam int report_timeout = 200000;    // Clk cycles allowed for one pass

	logic                     clk;
	logic                     rst;
	logic                     miso;
	logic                     sclk;
	logic                     ss;
	logic                     mosi;
	flash_pkg::pass_report_t  report;
	logic                     report_valid;
	logic [7:0]               busy_polls;
	logic                     corrupt_en;
	logic [23:0]              corrupt_addr;
	logic                     random_busy;
	logic [31:0]              rng_state;
	int                       violations;
	int                       erase_count;
	int                       program_count;
	flash_pkg::pass_report_t  rep;

	flash_exerciser_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.miso         (miso),
		.sclk         (sclk),
		.ss           (ss),
		.mosi         (mosi),
		.report       (report),
		.report_valid (report_valid)
	);

	spi_flash_model flash_i (
		.sclk          (sclk),
		.ss            (ss),
		.mosi          (mosi),
		.miso          (miso),
		.busy_polls    (busy_polls),
		.corrupt_en    (corrupt_en),
		.corrupt_addr  (corrupt_addr),
		.violations    (violations),
		.erase_count   (erase_count),
		.program_count (program_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = !clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always @(posedge clk) begin
		if (random_busy) begin
			rng_state = lcg_next(rng_state);
			busy_polls <= 8'd1 + rng_state[23:16] % 8'd20;    // 1 to 20 polls
		end
	end

	// ##########################################################################
	// Compare tasks
	// ##########################################################################

	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_report(input flash_pkg::pass_report_t got, input logic [15:0] pass_no,
			input logic [15:0] errors, input logic [23:0] bad);
		flash_pkg::pass_report_t exp;
		exp.pass_no        = pass_no;
		exp.errors         = errors;
		exp.first_bad_addr = bad;
		if (got !== exp)
			report_mismatch("report {pass_no, errors, first_bad_addr}", got, exp);
	endtask

	task automatic wait_report(output flash_pkg::pass_report_t r);
		int  n;
		bit  got;
		n   = 0;
		got = 1'b0;
		while (!got && n < report_timeout) begin
			@(negedge clk);
			if (report_valid) begin
				r   = report;
				got = 1'b1;
			end
			n++;
		end
		if (!got) begin
			$display("No pass report arrived within %0d clock cycles", report_timeout);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_memory(input logic [7:0] seed);
		for (int a = 0; a < flash_pkg::mem_bytes; a++)
			check_byte($sformatf("flash byte %0d", a), flash_i.mem[a], seed + 8'(a));
	endtask

	// ##########################################################################
	// Directed tests
	// ##########################################################################

	task automatic test_reset_state();
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (i == 3)
				rst <= 1'b0;
			@(negedge clk);
			check_bit("ss in reset", ss, 1'b1);
			check_bit("sclk in reset", sclk, 1'b0);
			check_bit("mosi in reset", mosi, 1'b0);
			check_bit("report_valid in reset", report_valid, 1'b0);
		end
		@(negedge clk);
		check_bit("ss after reset", ss, 1'b1);
		check_bit("sclk after reset", sclk, 1'b0);
		check_bit("mosi after reset", mosi, 1'b0);
		check_bit("report_valid after reset", report_valid, 1'b0);
	endtask

	task automatic test_command_order();
		wait_report(rep);
		check_count("command violations", violations, 0);
		check_count("sector erases", erase_count, 1);
		check_count("byte programs", program_count, flash_pkg::mem_bytes);
		check_memory(8'd1);                        // Pass 1 contents
		check_report(rep, 16'd1, 16'd0, 24'd0);
	endtask

	task automatic test_fault_detection();
		logic [23:0] bad;
		rng_state = lcg_next(rng_state);
		bad       = 24'(rng_state[15:8] % 8'(flash_pkg::mem_bytes));
		@(posedge clk);
		corrupt_addr <= bad;
		corrupt_en   <= 1'b1;
		wait_report(rep);
		check_report(rep, 16'd2, 16'd1, bad);
		check_memory(8'd2);
		@(posedge clk);
		corrupt_en <= 1'b0;
	endtask

	task automatic test_busy_polling();
		@(posedge clk);
		random_busy <= 1'b1;
		wait_report(rep);
		check_report(rep, 16'd3, 16'd0, 24'd0);
		check_count("command violations", violations, 0);
		check_memory(8'd3);
	endtask

	initial begin
		rst          = 1'b1;
		busy_polls   = 8'd3;
		corrupt_en   = 1'b0;
		corrupt_addr = '0;
		random_busy  = 1'b0;
		rng_state    = 32'hcec0;
		test_reset_state();
		test_command_order();
		test_fault_detection();
		test_busy_polling();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/flash_pkg.sv
hdl/spi_shift_engine.sv
hdl/readback_checker.sv
hdl/flash_cmd_sequencer.sv
hdl/flash_exerciser_top.sv
tb/spi_flash_model.sv
tb/tb_flash_exerciser.sv
